// ==== Makefile ====
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
TOP       ?= mcu_pwr_tb
FILELIST  ?= mcu_pwr.f
OBJ_DIR   ?= obj_dir
PASS_MSG  := Simulation passed

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  help   list the targets"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the build directory"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	@out="$$(./$(OBJ_DIR)/V$(TOP) 2>&1)"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

// ==== hdl/irq_pkg.sv ====
// ##########################################################################
// interrupt vector types for the single core hart
// ##########################################################################

`default_nettype none

`include "mcu_pwr_cfg.svh"

package irq_pkg;

  // full core interrupt vector
  typedef logic [`MCU_IRQ_W-1:0] irq_vec_t;

  // fast interrupt field, sits at MCU_IRQ_FAST_LSB in the vector
  typedef logic [`MCU_FAST_W-1:0] fast_irq_t;

  // always-on gpio lines
  typedef logic [`MCU_GPIO_AO_W-1:0] gpio_ao_irq_t;

  // timer 0 and 1 are always-on, timer 2 and 3 live in the peripheral domain
  typedef logic [`MCU_TIMER_W-1:0] timer_irq_t;

endpackage

`default_nettype wire

// ==== hdl/irq_vector.sv ====
// ##########################################################################
// registered core interrupt vector, one cycle from source to irq_o
// peripheral-domain sources read 0 while that domain is isolated
// ##########################################################################

`timescale 1ns/1ps
`default_nettype none

`include "mcu_pwr_cfg.svh"

module irq_vector import irq_pkg::*; (
  input  logic         clk_i,
  input  logic         reset_i,
  input  logic         irq_software_i,
  input  logic         irq_external_i,
  input  logic         dma_done_intr_i,
  input  logic         spi_intr_i,
  input  logic         spi_flash_intr_i,
  input  logic         periph_iso_ni,
  input  timer_irq_t   rv_timer_intr_i,
  input  gpio_ao_irq_t gpio_ao_intr_i,
  output irq_vec_t     irq_o,
  output logic         irq_pending_o
);

  timer_irq_t timer_c;
  fast_irq_t  fast_d;
  irq_vec_t   irq_d;
  irq_vec_t   irq_q;

  always_comb begin
    // timers 2 and 3 sit behind the peripheral isolation cells
    timer_c      = rv_timer_intr_i;
    timer_c[3:2] = rv_timer_intr_i[3:2] & {2{periph_iso_ni}};

    fast_d                       = '0;
    fast_d[2:0]                  = timer_c[3:1];
    fast_d[3]                    = dma_done_intr_i;
    fast_d[4]                    = spi_intr_i & periph_iso_ni;
    fast_d[5]                    = spi_flash_intr_i;
    fast_d[6 +: `MCU_GPIO_AO_W]  = gpio_ao_intr_i;

    irq_d                                   = '0;
    irq_d[`MCU_IRQ_SW_BIT]                  = irq_software_i & periph_iso_ni;
    irq_d[`MCU_IRQ_TIMER_BIT]               = timer_c[0];
    irq_d[`MCU_IRQ_EXT_BIT]                 = irq_external_i & periph_iso_ni;
    irq_d[`MCU_IRQ_FAST_LSB +: `MCU_FAST_W] = fast_d;
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      irq_q <= '0;
    end else begin
      irq_q <= irq_d;
    end
  end

  assign irq_o         = irq_q;
  assign irq_pending_o = |irq_q;

  // reserved positions never reach the core
  assert property (@(posedge clk_i) disable iff (reset_i)
    !irq_o[`MCU_IRQ_W-1] && !irq_o[`MCU_IRQ_FAST_LSB + `MCU_FAST_W - 1]);

endmodule

`default_nettype wire

// ==== hdl/mcu_pwr_cfg.svh ====
// ##########################################################################
// sizing and interrupt bit positions of the always-on core
// bit positions must stay below MCU_IRQ_FAST_LSB, fast field ends at bit 30
// ##########################################################################

`ifndef MCU_PWR_CFG_SVH
`define MCU_PWR_CFG_SVH

// memory banks with their own power switch
`define MCU_NUM_BANKS 4

// core interrupt vector and its fast field
`define MCU_IRQ_W 32
`define MCU_FAST_W 15

// source widths
`define MCU_GPIO_AO_W 8
`define MCU_TIMER_W 4

// standard interrupt positions in the core vector
`define MCU_IRQ_SW_BIT 3
`define MCU_IRQ_TIMER_BIT 7
`define MCU_IRQ_EXT_BIT 11
`define MCU_IRQ_FAST_LSB 16

`endif

// ==== hdl/mcu_pwr_top.sv ====
// ##########################################################################
// always-on power and interrupt core, power manager plus interrupt vector
// all power control outputs are active low
// ##########################################################################

`timescale 1ns/1ps
`default_nettype none

`include "mcu_pwr_cfg.svh"

module mcu_pwr_top import pwr_pkg::*, irq_pkg::*; (
  input  logic         clk_i,
  input  logic         reset_i,
  input  logic         cpu_pwr_down_req_i,
  input  logic         core_sleep_i,
  input  logic         periph_pwr_off_i,
  input  logic         ndmreset_ni,
  input  logic         cpu_ack_ni,
  input  logic         periph_ack_ni,
  input  bank_vec_t    bank_pwr_off_i,
  input  bank_vec_t    bank_ack_ni,
  input  bank_vec_t    bank_retentive_i,
  input  logic         irq_software_i,
  input  logic         irq_external_i,
  input  logic         dma_done_intr_i,
  input  logic         spi_intr_i,
  input  logic         spi_flash_intr_i,
  input  timer_irq_t   rv_timer_intr_i,
  input  gpio_ao_irq_t gpio_ao_intr_i,
  output logic         cpu_switch_no,
  output logic         cpu_iso_no,
  output logic         cpu_rst_no,
  output logic         cpu_clkgate_en_no,
  output logic         periph_switch_no,
  output logic         periph_iso_no,
  output logic         periph_rst_no,
  output logic         periph_clkgate_en_no,
  output bank_vec_t    bank_switch_no,
  output bank_vec_t    bank_iso_no,
  output bank_vec_t    bank_clkgate_en_no,
  output bank_vec_t    bank_retentive_no,
  output logic         cpu_on_o,
  output logic         periph_on_o,
  output bank_vec_t    bank_on_o,
  output irq_vec_t     irq_o
);

  logic irq_pending;

  pwr_manager pwr_manager_i (
    .clk_i,
    .reset_i,
    .cpu_pwr_down_req_i,
    .core_sleep_i,
    .irq_pending_i(irq_pending),
    .periph_pwr_off_i,
    .ndmreset_ni,
    .cpu_ack_ni,
    .periph_ack_ni,
    .bank_pwr_off_i,
    .bank_ack_ni,
    .bank_retentive_i,
    .cpu_switch_no,
    .cpu_iso_no,
    .cpu_rst_no,
    .cpu_clkgate_en_no,
    .periph_switch_no,
    .periph_iso_no,
    .periph_rst_no,
    .periph_clkgate_en_no,
    .bank_switch_no,
    .bank_iso_no,
    .bank_clkgate_en_no,
    .bank_retentive_no,
    .cpu_on_o,
    .periph_on_o,
    .bank_on_o
  );

  // peripheral isolation also clamps that domain's interrupt sources
  irq_vector irq_vector_i (
    .clk_i,
    .reset_i,
    .irq_software_i,
    .irq_external_i,
    .dma_done_intr_i,
    .spi_intr_i,
    .spi_flash_intr_i,
    .periph_iso_ni(periph_iso_no),
    .rv_timer_intr_i,
    .gpio_ao_intr_i,
    .irq_o,
    .irq_pending_o(irq_pending)
  );

endmodule

`default_nettype wire

// ==== hdl/pwr_domain_fsm.sv ====
// ##########################################################################
// one power domain sequencer, all outputs active low and decoded from state
// the switch acknowledge is waited for with no timeout
// ##########################################################################

`timescale 1ns/1ps
`default_nettype none

`include "mcu_pwr_cfg.svh"

module pwr_domain_fsm import pwr_pkg::*; (
  input  logic clk_i,
  input  logic reset_i,
  input  logic off_req_i,
  input  logic ack_ni,
  output logic switch_no,
  output logic iso_no,
  output logic rst_no,
  output logic clkgate_en_no,
  output logic on_o
);

  pwr_state_e state_q;
  pwr_state_e state_d;

  // request is only looked at in the two stable states
  always_comb begin
    state_d = state_q;
    unique case (state_q)
      ON: begin
        if (off_req_i) begin
          state_d = GATE_CLK;
        end
      end
      GATE_CLK:    state_d = ISOLATE;
      ISOLATE:     state_d = HOLD_RST;
      HOLD_RST:    state_d = SWITCH_OFF;
      SWITCH_OFF: begin
        // switch reported open
        if (ack_ni) begin
          state_d = OFF;
        end
      end
      OFF: begin
        if (!off_req_i) begin
          state_d = SWITCH_ON;
        end
      end
      SWITCH_ON: begin
        // switch reported closed
        if (!ack_ni) begin
          state_d = RELEASE_RST;
        end
      end
      RELEASE_RST: state_d = RELEASE_ISO;
      RELEASE_ISO: state_d = ON;
      default:     state_d = ON;
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      state_q <= ON;
    end else begin
      state_q <= state_d;
    end
  end

  // output decode, defaults are the powered values
  always_comb begin
    switch_no     = 1'b0;
    iso_no        = 1'b1;
    rst_no        = 1'b1;
    clkgate_en_no = 1'b1;
    on_o          = 1'b1;
    unique case (state_q)
      ON: begin
      end
      GATE_CLK: begin
        clkgate_en_no = 1'b0;
      end
      ISOLATE: begin
        clkgate_en_no = 1'b0;
        iso_no        = 1'b0;
      end
      HOLD_RST: begin
        clkgate_en_no = 1'b0;
        iso_no        = 1'b0;
        rst_no        = 1'b0;
      end
      SWITCH_OFF: begin
        clkgate_en_no = 1'b0;
        iso_no        = 1'b0;
        rst_no        = 1'b0;
        switch_no     = 1'b1;
      end
      OFF: begin
        clkgate_en_no = 1'b0;
        iso_no        = 1'b0;
        rst_no        = 1'b0;
        switch_no     = 1'b1;
        on_o          = 1'b0;
      end
      SWITCH_ON: begin
        clkgate_en_no = 1'b0;
        iso_no        = 1'b0;
        rst_no        = 1'b0;
        on_o          = 1'b0;
      end
      RELEASE_RST: begin
        clkgate_en_no = 1'b0;
        iso_no        = 1'b0;
        on_o          = 1'b0;
      end
      RELEASE_ISO: begin
        clkgate_en_no = 1'b0;
        on_o          = 1'b0;
      end
      default: begin
      end
    endcase
  end

  // an unpowered domain must never drive its neighbours
  assert property (@(posedge clk_i) disable iff (reset_i) switch_no |-> !iso_no);

  // and must sit in reset for the whole time it is unpowered
  assert property (@(posedge clk_i) disable iff (reset_i) switch_no |-> !rst_no);

endmodule

`default_nettype wire

// ==== hdl/pwr_manager.sv ====
// ##########################################################################
// always-on power manager for cpu, peripheral domain and memory banks
// the cpu only sleeps with no interrupt pending; banks have no reset output
// ##########################################################################

`timescale 1ns/1ps
`default_nettype none

`include "mcu_pwr_cfg.svh"

module pwr_manager import pwr_pkg::*; (
  input  logic      clk_i,
  input  logic      reset_i,
  input  logic      cpu_pwr_down_req_i,
  input  logic      core_sleep_i,
  input  logic      irq_pending_i,
  input  logic      periph_pwr_off_i,
  input  logic      ndmreset_ni,
  input  logic      cpu_ack_ni,
  input  logic      periph_ack_ni,
  input  bank_vec_t bank_pwr_off_i,
  input  bank_vec_t bank_ack_ni,
  input  bank_vec_t bank_retentive_i,
  output logic      cpu_switch_no,
  output logic      cpu_iso_no,
  output logic      cpu_rst_no,
  output logic      cpu_clkgate_en_no,
  output logic      periph_switch_no,
  output logic      periph_iso_no,
  output logic      periph_rst_no,
  output logic      periph_clkgate_en_no,
  output bank_vec_t bank_switch_no,
  output bank_vec_t bank_iso_no,
  output bank_vec_t bank_clkgate_en_no,
  output bank_vec_t bank_retentive_no,
  output logic      cpu_on_o,
  output logic      periph_on_o,
  output bank_vec_t bank_on_o
);

  logic      cpu_off_req;
  logic      cpu_rst_n;
  logic      periph_rst_n;
  bank_vec_t bank_retentive_q;

  // any pending interrupt drops the request, which wakes the cpu
  assign cpu_off_req = cpu_pwr_down_req_i & core_sleep_i & ~irq_pending_i;

  pwr_domain_fsm cpu_fsm_i (
    .clk_i,
    .reset_i,
    .off_req_i    (cpu_off_req),
    .ack_ni       (cpu_ack_ni),
    .switch_no    (cpu_switch_no),
    .iso_no       (cpu_iso_no),
    .rst_no       (cpu_rst_n),
    .clkgate_en_no(cpu_clkgate_en_no),
    .on_o         (cpu_on_o)
  );

  pwr_domain_fsm periph_fsm_i (
    .clk_i,
    .reset_i,
    .off_req_i    (periph_pwr_off_i),
    .ack_ni       (periph_ack_ni),
    .switch_no    (periph_switch_no),
    .iso_no       (periph_iso_no),
    .rst_no       (periph_rst_n),
    .clkgate_en_no(periph_clkgate_en_no),
    .on_o         (periph_on_o)
  );

  for (genvar i = 0; i < `MCU_NUM_BANKS; i++) begin : gen_bank
    pwr_domain_fsm bank_fsm_i (
      .clk_i,
      .reset_i,
      .off_req_i    (bank_pwr_off_i[i]),
      .ack_ni       (bank_ack_ni[i]),
      .switch_no    (bank_switch_no[i]),
      .iso_no       (bank_iso_no[i]),
      .rst_no       (),
      .clkgate_en_no(bank_clkgate_en_no[i]),
      .on_o         (bank_on_o[i])
    );

    // retention only means something on a powered bank
    assign bank_retentive_no[i] = bank_retentive_q[i] | ~bank_on_o[i];

    assert property (@(posedge clk_i) disable iff (reset_i)
      !bank_on_o[i] |-> bank_retentive_no[i]);
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      bank_retentive_q <= '1;
    end else begin
      bank_retentive_q <= ~bank_retentive_i;
    end
  end

  // debug module reset overrides the sequencer resets
  assign cpu_rst_no    = cpu_rst_n & ndmreset_ni;
  assign periph_rst_no = periph_rst_n & ndmreset_ni;

endmodule

`default_nettype wire

// ==== hdl/pwr_pkg.sv ====
// ##########################################################################
// power manager types, all domains share one sequencer encoding
// ##########################################################################

`default_nettype none

`include "mcu_pwr_cfg.svh"

package pwr_pkg;

  // domain sequencer states
  // power-down walks GATE_CLK to OFF, power-up walks SWITCH_ON back to ON
  typedef enum logic [3:0] {
    ON,
    GATE_CLK,
    ISOLATE,
    HOLD_RST,
    SWITCH_OFF,
    OFF,
    SWITCH_ON,
    RELEASE_RST,
    RELEASE_ISO
  } pwr_state_e;

  // one bit per memory bank
  typedef logic [`MCU_NUM_BANKS-1:0] bank_vec_t;

endpackage

`default_nettype wire

// ==== mcu_pwr.f ====
+incdir+hdl
hdl/pwr_pkg.sv
hdl/irq_pkg.sv
hdl/pwr_domain_fsm.sv
hdl/pwr_manager.sv
hdl/irq_vector.sv
hdl/mcu_pwr_top.sv
tb/mcu_pwr_tb.sv

// ==== tb/mcu_pwr_tb.sv ====
// ##########################################################################
// inputs change 2 ns after the rising edge and outputs are sampled on the
// falling edge; the run stops at the first error
// ##########################################################################

`timescale 1ns/1ps
`default_nettype none

`include "mcu_pwr_cfg.svh"

module mcu_pwr_tb import pwr_pkg::*, irq_pkg::*; ();

  // grouped vectors hold cpu, periph, then the banks
  localparam int NDOM = `MCU_NUM_BANKS + 2;
  localparam int STIM_W = 29;
  localparam int SETTLE_CYCLES = 50;

  logic clk_i = 1'b0;
  logic reset_i;
  logic cpu_pwr_down_req_i, core_sleep_i, periph_pwr_off_i, ndmreset_ni;
  logic cpu_ack_ni, periph_ack_ni;
  bank_vec_t bank_pwr_off_i, bank_ack_ni, bank_retentive_i;
  logic irq_software_i, irq_external_i, dma_done_intr_i, spi_intr_i, spi_flash_intr_i;
  timer_irq_t rv_timer_intr_i;
  gpio_ao_irq_t gpio_ao_intr_i;
  logic cpu_switch_no, cpu_iso_no, cpu_rst_no, cpu_clkgate_en_no;
  logic periph_switch_no, periph_iso_no, periph_rst_no, periph_clkgate_en_no;
  bank_vec_t bank_switch_no, bank_iso_no, bank_clkgate_en_no, bank_retentive_no;
  logic cpu_on_o, periph_on_o;
  bank_vec_t bank_on_o;
  irq_vec_t irq_o;

  integer seed = 32'h25e8_7fa5;
  logic [NDOM-1:0] ack_v = '0;
  int unsigned ack_cnt [NDOM] = '{default: 0};

  logic [NDOM-1:0] sw_v;
  logic [NDOM-1:0] iso_v;
  logic [NDOM-1:0] cg_v;
  logic [NDOM-1:0] on_v;
  logic [1:0] rst_v;

  string name_q [$];
  logic [STIM_W-1:0] stim_q [$];
  logic seq_q [$];
  logic [NDOM-1:0] exp_on_q [$];
  irq_vec_t exp_irq_q [$];
  bank_vec_t exp_ret_q [$];
  logic [1:0] exp_rst_q [$];

  mcu_pwr_top DUT (.*);

  always #20 clk_i = ~clk_i;

  assign sw_v  = {bank_switch_no, periph_switch_no, cpu_switch_no};
  assign iso_v = {bank_iso_no, periph_iso_no, cpu_iso_no};
  assign cg_v  = {bank_clkgate_en_no, periph_clkgate_en_no, cpu_clkgate_en_no};
  assign on_v  = {bank_on_o, periph_on_o, cpu_on_o};
  assign rst_v = {periph_rst_no, cpu_rst_no};

  assign cpu_ack_ni    = ack_v[0];
  assign periph_ack_ni = ack_v[1];
  assign bank_ack_ni   = ack_v[NDOM-1:2];

  // switch model returns each ack 1 to 4 cycles after its switch moves
  always @(posedge clk_i) begin
    #2;
    for (int d = 0; d < NDOM; d++) begin
      if (ack_v[d] == sw_v[d]) begin
        ack_cnt[d] = 0;
      end else if (ack_cnt[d] == 0) begin
        ack_cnt[d] = 1 + ($unsigned($random(seed)) % 4);
      end else begin
        ack_cnt[d] = ack_cnt[d] - 1;
        if (ack_cnt[d] == 0) begin
          ack_v[d] = sw_v[d];
        end
      end
    end
  end

  function automatic string domain_name(input int d);
    if (d == 0) begin
      return "cpu";
    end else if (d == 1) begin
      return "periph";
    end
    return $sformatf("bank %0d", d - 2);
  endfunction

  task automatic fail_run(input string msg);
    $display("%s", msg);
    $display("Simulation failed");
    $fatal(1, "stopped at first error");
  endtask

  task automatic compare_value(input string test, input string what,
                               input logic [31:0] exp, input logic [31:0] act);
    assert (act === exp) else
      fail_run($sformatf("Mismatch %s %s: expected %h, actual %h", test, what, exp, act));
  endtask

  task automatic report_stuck(input string test, input logic [NDOM-1:0] exp_on);
    string msg;
    msg = $sformatf("status never settled in %s for:", test);
    for (int d = 0; d < NDOM; d++) begin
      if (on_v[d] !== exp_on[d]) begin
        msg = {msg, " ", domain_name(d)};
      end
    end
    fail_run(msg);
  endtask

  // clock gate, isolation, reset and switch must nest in both directions
  // and the switch ack has to arrive before status falls or isolation lifts
  task automatic enforce_edge_order(input string test);
    logic [NDOM-1:0] ok;
    ok = (~cg_v | iso_v) & (~iso_v | ~sw_v) & (~cg_v | on_v);
    ok = ok & (on_v | ~sw_v | ack_v) & (~iso_v | ~ack_v);
    if (ndmreset_ni) begin
      ok[1:0] = ok[1:0] & (~iso_v[1:0] | rst_v) & (~rst_v | ~sw_v[1:0]);
    end
    assert (&ok) else
      fail_run($sformatf("power control edges out of order in %s, domains %b", test, ~ok));
  endtask

  // one control edge per cycle from k+1 to k+4 after a request driven past edge k
  task automatic watch_power_down(input string test);
    logic [3:0] want;
    logic [4:0] act;
    for (int s = 1; s <= 4; s++) begin
      @(posedge clk_i);
      @(negedge clk_i);
      want = {1'b0, s < 2, s < 3, s >= 4};
      act  = {periph_clkgate_en_no, periph_iso_no, periph_rst_no, periph_switch_no,
              periph_on_o};
      assert (act === {want, 1'b1}) else
        fail_run($sformatf("Mismatch %s step %0d: expected %b, actual %b",
                           test, s, {want, 1'b1}, act));
    end
  endtask

  task automatic add_row(input string test, input logic [3:0] ctl, input bank_vec_t bank_off,
                         input bank_vec_t bank_ret, input logic [4:0] src,
                         input timer_irq_t timer, input gpio_ao_irq_t gpio, input logic seq,
                         input logic [NDOM-1:0] exp_on, input irq_vec_t exp_irq,
                         input bank_vec_t exp_ret, input logic [1:0] exp_rst);
    name_q.push_back(test);
    stim_q.push_back({ctl, bank_off, bank_ret, src, timer, gpio});
    seq_q.push_back(seq);
    exp_on_q.push_back(exp_on);
    exp_irq_q.push_back(exp_irq);
    exp_ret_q.push_back(exp_ret);
    exp_rst_q.push_back(exp_rst);
  endtask

  // ctl bits are cpu_pwr_down_req, core_sleep, periph_pwr_off, ndmreset_n
  // src bits are software, external, dma done, spi, spi flash
  // expected status is bank 3..0, periph, cpu and expected rst_n is periph, cpu
  task automatic build_table();
    add_row("reset_state", 4'b0001, 4'b0000, 4'b0000, 5'b00000, 4'h0, 8'h00, 1'b0,
            6'b111111, 32'h0000_0000, 4'b1111, 2'b11);
    add_row("irq_software", 4'b0001, 4'b0000, 4'b0000, 5'b10000, 4'h0, 8'h00, 1'b0,
            6'b111111, 32'h0000_0008, 4'b1111, 2'b11);
    add_row("irq_external", 4'b0001, 4'b0000, 4'b0000, 5'b01000, 4'h0, 8'h00, 1'b0,
            6'b111111, 32'h0000_0800, 4'b1111, 2'b11);
    add_row("irq_dma_done", 4'b0001, 4'b0000, 4'b0000, 5'b00100, 4'h0, 8'h00, 1'b0,
            6'b111111, 32'h0008_0000, 4'b1111, 2'b11);
    add_row("irq_spi", 4'b0001, 4'b0000, 4'b0000, 5'b00010, 4'h0, 8'h00, 1'b0,
            6'b111111, 32'h0010_0000, 4'b1111, 2'b11);
    add_row("irq_spi_flash", 4'b0001, 4'b0000, 4'b0000, 5'b00001, 4'h0, 8'h00, 1'b0,
            6'b111111, 32'h0020_0000, 4'b1111, 2'b11);
    add_row("irq_timer0", 4'b0001, 4'b0000, 4'b0000, 5'b00000, 4'h1, 8'h00, 1'b0,
            6'b111111, 32'h0000_0080, 4'b1111, 2'b11);
    add_row("irq_timer1", 4'b0001, 4'b0000, 4'b0000, 5'b00000, 4'h2, 8'h00, 1'b0,
            6'b111111, 32'h0001_0000, 4'b1111, 2'b11);
    add_row("irq_timer2", 4'b0001, 4'b0000, 4'b0000, 5'b00000, 4'h4, 8'h00, 1'b0,
            6'b111111, 32'h0002_0000, 4'b1111, 2'b11);
    add_row("irq_timer3", 4'b0001, 4'b0000, 4'b0000, 5'b00000, 4'h8, 8'h00, 1'b0,
            6'b111111, 32'h0004_0000, 4'b1111, 2'b11);
    add_row("irq_gpio0", 4'b0001, 4'b0000, 4'b0000, 5'b00000, 4'h0, 8'h01, 1'b0,
            6'b111111, 32'h0040_0000, 4'b1111, 2'b11);
    add_row("irq_gpio7", 4'b0001, 4'b0000, 4'b0000, 5'b00000, 4'h0, 8'h80, 1'b0,
            6'b111111, 32'h2000_0000, 4'b1111, 2'b11);
    add_row("irq_all", 4'b0001, 4'b0000, 4'b0000, 5'b11111, 4'hf, 8'hff, 1'b0,
            6'b111111, 32'h3fff_0888, 4'b1111, 2'b11);
    // peripheral sources drop out once the domain is isolated
    add_row("periph_down", 4'b0011, 4'b0000, 4'b0000, 5'b11111, 4'hf, 8'hff, 1'b1,
            6'b111101, 32'h3fe9_0080, 4'b1111, 2'b01);
    add_row("bank_down", 4'b0011, 4'b0101, 4'b0000, 5'b00000, 4'h0, 8'h00, 1'b0,
            6'b101001, 32'h0000_0000, 4'b1111, 2'b01);
    add_row("bank_up", 4'b0011, 4'b0000, 4'b0000, 5'b00000, 4'h0, 8'h00, 1'b0,
            6'b111101, 32'h0000_0000, 4'b1111, 2'b01);
    add_row("periph_up", 4'b0001, 4'b0000, 4'b0000, 5'b10000, 4'h0, 8'h00, 1'b0,
            6'b111111, 32'h0000_0008, 4'b1111, 2'b11);
    add_row("cpu_sleep", 4'b1101, 4'b0000, 4'b0000, 5'b00000, 4'h0, 8'h00, 1'b0,
            6'b111110, 32'h0000_0000, 4'b1111, 2'b10);
    add_row("cpu_wake_gpio", 4'b1101, 4'b0000, 4'b0000, 5'b00000, 4'h0, 8'h04, 1'b0,
            6'b111111, 32'h0100_0000, 4'b1111, 2'b11);
    // bank 3 is off and asks for retention, which it must not get
    add_row("bank_retention", 4'b0001, 4'b1000, 4'b1111, 5'b00000, 4'h0, 8'h00, 1'b0,
            6'b011111, 32'h0000_0000, 4'b1000, 2'b11);
    add_row("ndmreset", 4'b0000, 4'b1000, 4'b1111, 5'b00000, 4'h0, 8'h00, 1'b0,
            6'b011111, 32'h0000_0000, 4'b1000, 2'b00);
    add_row("release_all", 4'b0001, 4'b0000, 4'b0000, 5'b00000, 4'h0, 8'h00, 1'b0,
            6'b111111, 32'h0000_0000, 4'b1111, 2'b11);
  endtask

  task automatic run_row(input int i);
    string test;
    int cyc;
    logic [NDOM-1:0] exp_on;
    logic [NDOM-1:0] exp_off;
    test    = name_q[i];
    exp_on  = exp_on_q[i];
    exp_off = ~exp_on;
    @(posedge clk_i);
    #2;
    {cpu_pwr_down_req_i, core_sleep_i, periph_pwr_off_i, ndmreset_ni, bank_pwr_off_i,
     bank_retentive_i, irq_software_i, irq_external_i, dma_done_intr_i, spi_intr_i,
     spi_flash_intr_i, rv_timer_intr_i, gpio_ao_intr_i} = stim_q[i];
    if (seq_q[i]) begin
      watch_power_down(test);
    end
    for (cyc = 0; cyc < SETTLE_CYCLES; cyc++) begin
      @(negedge clk_i);
      enforce_edge_order(test);
      if (on_v === exp_on) begin
        break;
      end
    end
    if (cyc == SETTLE_CYCLES) begin
      report_stuck(test, exp_on);
    end else begin
      // one more edge for the registered vector and retention
      @(posedge clk_i);
      @(negedge clk_i);
      compare_value(test, "status", 32'(exp_on), 32'(on_v));
      compare_value(test, "switch_n", 32'(exp_off), 32'(sw_v));
      compare_value(test, "iso_n", 32'(exp_on), 32'(iso_v));
      compare_value(test, "clkgate_en_n", 32'(exp_on), 32'(cg_v));
      compare_value(test, "rst_n", 32'(exp_rst_q[i]), 32'(rst_v));
      compare_value(test, "retentive_n", 32'(exp_ret_q[i]), 32'(bank_retentive_no));
      compare_value(test, "irq_o", exp_irq_q[i], irq_o);
    end
  endtask

  initial begin
    reset_i            = 1'b1;
    cpu_pwr_down_req_i = 1'b0;
    core_sleep_i       = 1'b0;
    periph_pwr_off_i   = 1'b0;
    ndmreset_ni        = 1'b1;
    bank_pwr_off_i     = '0;
    bank_retentive_i   = '0;
    irq_software_i     = 1'b0;
    irq_external_i     = 1'b0;
    dma_done_intr_i    = 1'b0;
    spi_intr_i         = 1'b0;
    spi_flash_intr_i   = 1'b0;
    rv_timer_intr_i    = '0;
    gpio_ao_intr_i     = '0;
    build_table();
    repeat (8) @(posedge clk_i);
    #2;
    reset_i = 1'b0;
    for (int i = 0; i < name_q.size(); i++) begin
      run_row(i);
    end
    $display("Simulation passed");
    $finish;
  end

endmodule

`default_nettype wire
